/* src/fpu_params.svh */
// FP16 sizes and limits; ALIGN_MAX must stay at least FP16_FRACW + GRS_W + 1 so far bits reach sticky.
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// Half-precision word layout.
`define FP16_W 16
`define FP16_EXPW 5
`define FP16_FRACW 10
`define FP16_BIAS 15

// Largest biased exponent of a finite value.
`define FP16_EXP_MAX 30

// Guard, round and sticky bits kept below the fraction.
`define GRS_W 3

// Carry, integer, fraction and GRS bits of the raw sum.
`define SUM_W (`FP16_FRACW + `GRS_W + 2)

// Cap on alignment shifts; beyond it all small bits sit in sticky.
`define ALIGN_MAX 14

// Width of the alignment count, must hold ALIGN_MAX.
`define ALIGN_CNTW 4

`endif

/* src/fpuTypesPkg.sv */
// FP16 data types only; the field layout assumes the widths in fpu_params.svh.
`include "fpu_params.svh"

package fpuTypesPkg;

  // IEEE half-precision fields, sign first.
  typedef struct packed {
    logic                     sign;
    logic [`FP16_EXPW - 1:0]  exp;
    logic [`FP16_FRACW - 1:0] frac;
  } fp16_t;

  // Same word seen as raw bits on ports and as fields inside the logic.
  typedef union packed {
    logic [`FP16_W - 1:0] raw;
    fp16_t                f;
  } fp16Word_u;

  // Status word: overflow, underflow, inexact.
  typedef struct packed {
    logic OF;
    logic UF;
    logic NX;
  } opStatusFlag_t;

endpackage : fpuTypesPkg

/* src/fpuCtrlPkg.sv */
// Controller state encoding for the multi-cycle adder; one operation in flight at a time.
package fpuCtrlPkg;

  // Step order of one add or subtract.
  // ALIGN repeats until the shift count is used up.
  typedef enum logic [2:0] {
    IDLE,
    PREP,
    ALIGN,
    ADD,
    NORM
  } ctrlState_t;

endpackage : fpuCtrlPkg

/* src/fpuAddSubCtrl.sv */
// Sequencer for the FP16 adder; start is ignored while busy and done pulses for one cycle.
module fpuAddSubCtrl (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic cntZero,
  output logic prepLoad,
  output logic cntLoad,
  output logic shiftEn,
  output logic addEn,
  output logic normEn,
  output logic busy,
  output logic done
);

  fpuCtrlPkg::ctrlState_t state;
  fpuCtrlPkg::ctrlState_t stateNext;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fpuCtrlPkg::IDLE;
      done  <= 1'b0;
    end else begin
      state <= stateNext;
      // Result lands on the same edge that leaves NORM.
      done  <= (state == fpuCtrlPkg::NORM);
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      fpuCtrlPkg::IDLE: begin
        if (start) begin
          stateNext = fpuCtrlPkg::PREP;
        end
      end
      fpuCtrlPkg::PREP: begin
        stateNext = fpuCtrlPkg::ALIGN;
      end
      // Leave only once the counter has run out.
      fpuCtrlPkg::ALIGN: begin
        if (cntZero) begin
          stateNext = fpuCtrlPkg::ADD;
        end
      end
      fpuCtrlPkg::ADD: begin
        stateNext = fpuCtrlPkg::NORM;
      end
      default: begin
        stateNext = fpuCtrlPkg::IDLE;
      end
    endcase
  end

  // Operands are captured on the accepting edge itself.
  assign prepLoad = (state == fpuCtrlPkg::IDLE) && start;
  assign cntLoad  = (state == fpuCtrlPkg::PREP);
  assign shiftEn  = (state == fpuCtrlPkg::ALIGN) && !cntZero;
  assign addEn    = (state == fpuCtrlPkg::ADD);
  assign normEn   = (state == fpuCtrlPkg::NORM);
  assign busy     = (state != fpuCtrlPkg::IDLE);

  // The alignment counter runs only in ALIGN and rests at zero elsewhere.
  assert property (@(posedge clk) disable iff (rst)
    (state != fpuCtrlPkg::ALIGN) |-> cntZero);

endmodule : fpuAddSubCtrl

/* src/fpuShiftCounter.sv */
// Alignment timer; a load wins over a decrement in the same cycle.
`include "fpu_params.svh"

module fpuShiftCounter (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cntLoad,
  input  logic                     shiftEn,
  input  logic [`ALIGN_CNTW - 1:0] loadValue,
  output logic                     cntZero
);

  logic [`ALIGN_CNTW - 1:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (cntLoad) begin
      count <= loadValue;
    end else if (shiftEn) begin
      count <= count - `ALIGN_CNTW'd1;
    end
  end

  assign cntZero = (count == '0);

  // Controller must stop shifting before the count wraps.
  assert property (@(posedge clk) disable iff (rst)
    (shiftEn && !cntLoad) |-> !cntZero);

endmodule : fpuShiftCounter

/* src/fpuOperandPrep.sv */
// Operand sort and special-value check; NaN payloads and signalling NaNs are not kept apart.
`include "fpu_params.svh"

module fpuOperandPrep (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     prepLoad,
  input  logic                     sub,
  input  logic [`FP16_W - 1:0]     opA,
  input  logic [`FP16_W - 1:0]     opB,
  output fpuTypesPkg::fp16_t       largeNum,
  output fpuTypesPkg::fp16_t       smallNum,
  output logic                     effSub,
  output logic                     special,
  output logic [`FP16_W - 1:0]     specialWord,
  output logic [`ALIGN_CNTW - 1:0] shiftAmt
);

  localparam logic [`FP16_W - 1:0] quietNaN = 16'h7E00;

  fpuTypesPkg::fp16Word_u wordA;
  fpuTypesPkg::fp16Word_u wordB;
  fpuTypesPkg::fp16_t     opBEff;
  fpuTypesPkg::fp16_t     largeNext;
  fpuTypesPkg::fp16_t     smallNext;
  logic nanA, nanB, infA, infB;
  logic effSubNext, specialNext;
  logic [`FP16_W - 1:0]     specialWordNext;
  logic [`FP16_EXPW - 1:0]  expLarge, expSmall, expDiff;
  logic [`ALIGN_CNTW - 1:0] shiftNext;

  always_comb begin
    wordA.raw = opA;
    wordB.raw = opB;

    // Subtraction is addition of B with its sign flipped.
    opBEff      = wordB.f;
    opBEff.sign = wordB.f.sign ^ sub;

    if ({wordA.f.exp, wordA.f.frac} >= {opBEff.exp, opBEff.frac}) begin
      largeNext = wordA.f;
      smallNext = opBEff;
    end else begin
      largeNext = opBEff;
      smallNext = wordA.f;
    end
    effSubNext = wordA.f.sign ^ opBEff.sign;

    nanA = (&wordA.f.exp) && (|wordA.f.frac);
    nanB = (&wordB.f.exp) && (|wordB.f.frac);
    infA = (&wordA.f.exp) && !(|wordA.f.frac);
    infB = (&wordB.f.exp) && !(|wordB.f.frac);
    specialNext = nanA | nanB | infA | infB;

    // An infinity is always the larger operand, sign already adjusted.
    if (nanA || nanB || (infA && infB && effSubNext)) begin
      specialWordNext = quietNaN;
    end else begin
      specialWordNext = largeNext;
    end

    // Subnormals sit at the scale of exponent 1.
    expLarge = (largeNext.exp == '0) ? `FP16_EXPW'd1 : largeNext.exp;
    expSmall = (smallNext.exp == '0) ? `FP16_EXPW'd1 : smallNext.exp;
    expDiff  = expLarge - expSmall;

    if (specialNext) begin
      shiftNext = '0;
    end else if (expDiff > `FP16_EXPW'(`ALIGN_MAX)) begin
      shiftNext = `ALIGN_CNTW'(`ALIGN_MAX);
    end else begin
      shiftNext = expDiff[`ALIGN_CNTW - 1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      effSub   <= 1'b0;
      special  <= 1'b0;
      shiftAmt <= '0;
    end else if (prepLoad) begin
      effSub   <= effSubNext;
      special  <= specialNext;
      shiftAmt <= shiftNext;
    end
  end

  always_ff @(posedge clk) begin
    if (prepLoad) begin
      largeNum    <= largeNext;
      smallNum    <= smallNext;
      specialWord <= specialWordNext;
    end
  end

endmodule : fpuOperandPrep

/* src/fpuAlignShifter.sv */
// Bit-serial aligner; expects sorted operands, so the difference never goes negative.
`include "fpu_params.svh"

module fpuAlignShifter (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    prepLoad,
  input  logic                    shiftEn,
  input  logic                    addEn,
  input  fpuTypesPkg::fp16_t      largeNum,
  input  fpuTypesPkg::fp16_t      smallNum,
  input  logic                    effSub,
  output logic [`SUM_W - 1:0]     sumSig,
  output logic                    sumSign,
  output logic [`FP16_EXPW - 1:0] sumExp
);

  localparam int sigW = `SUM_W - 1;

  logic              loadQ;
  logic [sigW - 1:0] alignSig;
  logic [sigW - 1:0] largeSig;
  logic [`SUM_W - 1:0] sumNext;

  // Operands settle one edge after prepLoad.
  always_ff @(posedge clk) begin
    if (rst) begin
      loadQ <= 1'b0;
    end else begin
      loadQ <= prepLoad;
    end
  end

  // Hidden bit is zero for subnormals.
  // Bit 0 is sticky and keeps everything shifted past round.
  always_ff @(posedge clk) begin
    if (loadQ) begin
      alignSig <= {|smallNum.exp, smallNum.frac, `GRS_W'd0};
    end else if (shiftEn) begin
      alignSig <= {1'b0, alignSig[sigW - 1:2], |alignSig[1:0]};
    end
  end

  always_comb begin
    largeSig = {|largeNum.exp, largeNum.frac, `GRS_W'd0};
    if (effSub) begin
      sumNext = {1'b0, largeSig} - {1'b0, alignSig};
    end else begin
      sumNext = {1'b0, largeSig} + {1'b0, alignSig};
    end
  end

  always_ff @(posedge clk) begin
    if (addEn) begin
      sumSig  <= sumNext;
      // x - x is +0; only -0 + -0 keeps the minus.
      sumSign <= largeNum.sign & ~(effSub && (sumNext == '0));
      sumExp  <= (largeNum.exp == '0) ? `FP16_EXPW'd1 : largeNum.exp;
    end
  end

endmodule : fpuAlignShifter

/* src/fpuNormalizer16.sv */
// Normalize and round to nearest-even only; sumExp must be at least 1, subnormals enter at 1.
`include "fpu_params.svh"

module fpuNormalizer16 (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       normEn,
  input  logic [`SUM_W - 1:0]        sumSig,
  input  logic                       sumSign,
  input  logic [`FP16_EXPW - 1:0]    sumExp,
  input  logic                       special,
  input  logic [`FP16_W - 1:0]       specialWord,
  output logic [`FP16_W - 1:0]       result,
  output fpuTypesPkg::opStatusFlag_t flags
);

  localparam int sigW  = `SUM_W - 1;
  localparam int lzcW  = $clog2(sigW + 1);
  localparam int expXW = `FP16_EXPW + 1;

  logic [lzcW - 1:0]           lzc;
  logic [`FP16_EXPW - 1:0]     expRoom;
  logic [`FP16_EXPW - 1:0]     lShift;
  logic [sigW - 1:0]           normSig;
  logic [expXW - 1:0]          normExp;
  logic [expXW - 1:0]          finalExp;
  logic [`FP16_FRACW + 1:0]    mant;
  logic guardBit, stickyBit, inexact, roundUp, overflow;
  fpuTypesPkg::fp16Word_u     resWord;
  fpuTypesPkg::opStatusFlag_t flagsNext;

  // Leading zeros of integer, fraction and GRS; the carry bit is handled apart.
  always_comb begin
    lzc = lzcW'(sigW);
    for (int i = 0; i < sigW; i++) begin
      if (sumSig[i]) begin
        lzc = lzcW'(sigW - 1 - i);
      end
    end
  end

  // Normalization.
  always_comb begin
    // Left shift stops at exponent 1, which leaves a subnormal.
    expRoom = sumExp - `FP16_EXPW'd1;
    if (`FP16_EXPW'(lzc) < expRoom) begin
      lShift = `FP16_EXPW'(lzc);
    end else begin
      lShift = expRoom;
    end

    if (sumSig[`SUM_W - 1]) begin
      normSig = {sumSig[`SUM_W - 1:2], |sumSig[1:0]};
      normExp = expXW'(sumExp) + expXW'(1);
    end else begin
      normSig = sumSig[sigW - 1:0] << lShift;
      normExp = expXW'(sumExp) - expXW'(lShift);
    end
  end

  // Rounding and packing.
  always_comb begin
    guardBit  = normSig[`GRS_W - 1];
    stickyBit = |normSig[`GRS_W - 2:0];
    inexact   = guardBit | stickyBit;
    roundUp   = guardBit & (stickyBit | normSig[`GRS_W]);
    mant = {1'b0, normSig[sigW - 1:`GRS_W]} + {{(`FP16_FRACW + 1){1'b0}}, roundUp};

    // Carry out renormalizes; no integer bit means subnormal or zero.
    if (mant[`FP16_FRACW + 1]) begin
      finalExp = normExp + expXW'(1);
    end else if (mant[`FP16_FRACW]) begin
      finalExp = normExp;
    end else begin
      finalExp = '0;
    end
    overflow = (finalExp > expXW'(`FP16_EXP_MAX));

    resWord.f.sign = sumSign;
    if (overflow) begin
      resWord.f.exp  = '1;
      resWord.f.frac = '0;
    end else begin
      resWord.f.exp  = finalExp[`FP16_EXPW - 1:0];
      resWord.f.frac = mant[`FP16_FRACW - 1:0];
    end

    // Overflow to infinity is never exact.
    flagsNext.OF = overflow;
    flagsNext.UF = (finalExp == '0) & inexact;
    flagsNext.NX = inexact | overflow;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
      flags  <= '0;
    end else if (normEn) begin
      if (special) begin
        result <= specialWord;
        flags  <= '0;
      end else begin
        result <= resWord.raw;
        flags  <= flagsNext;
      end
    end
  end

  // Finite sums reach the normalizer at exponent 1 or above.
  assert property (@(posedge clk) disable iff (rst)
    (normEn && !special) |-> (sumExp != '0));

endmodule : fpuNormalizer16

/* src/fpuAddSub.sv */
// FP16 add/subtract, round to nearest-even, not pipelined; done comes n + 4 cycles after start.
`include "fpu_params.svh"

module fpuAddSub (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  logic                       sub,
  input  logic [`FP16_W - 1:0]       opA,
  input  logic [`FP16_W - 1:0]       opB,
  output logic [`FP16_W - 1:0]       result,
  output fpuTypesPkg::opStatusFlag_t flags,
  output logic                       busy,
  output logic                       done
);

  logic prepLoad, cntLoad, shiftEn, addEn, normEn, cntZero;
  logic effSub, special;
  logic sumSign;
  logic [`FP16_W - 1:0]     specialWord;
  logic [`ALIGN_CNTW - 1:0] shiftAmt;
  logic [`SUM_W - 1:0]      sumSig;
  logic [`FP16_EXPW - 1:0]  sumExp;
  fpuTypesPkg::fp16_t largeNum;
  fpuTypesPkg::fp16_t smallNum;

  fpuAddSubCtrl ctrl (
    .clk, .rst, .start, .cntZero,
    .prepLoad, .cntLoad, .shiftEn, .addEn, .normEn, .busy, .done
  );

  fpuShiftCounter shiftCnt (
    .clk, .rst, .cntLoad, .shiftEn, .loadValue(shiftAmt), .cntZero
  );

  fpuOperandPrep prep (
    .clk, .rst, .prepLoad, .sub, .opA, .opB,
    .largeNum, .smallNum, .effSub, .special, .specialWord, .shiftAmt
  );

  fpuAlignShifter aligner (
    .clk, .rst, .prepLoad, .shiftEn, .addEn, .largeNum, .smallNum, .effSub,
    .sumSig, .sumSign, .sumExp
  );

  fpuNormalizer16 normalizer (
    .clk, .rst, .normEn, .sumSig, .sumSign, .sumExp, .special, .specialWord,
    .result, .flags
  );

endmodule : fpuAddSub

/* test/fpuAddSubModel.svh */
// Exact FP16 add/subtract reference, nearest-even only; every NaN result is the quiet NaN 7E00.
`ifndef FPU_ADD_SUB_MODEL_SVH
`define FPU_ADD_SUB_MODEL_SVH

// Signed value of a finite FP16 word in units of 2^-24.
function automatic logic signed [63:0] toUnits(input logic [15:0] w);
  logic [63:0] sig;
  int          e;
  e   = int'(w[14:10]);
  sig = (e != 0) ? 64'd1024 + 64'(w[9:0]) : 64'(w[9:0]);
  // Subnormals share the scale of exponent 1.
  if (e == 0) begin
    e = 1;
  end
  sig = sig << (e - 1);
  return w[15] ? -$signed(sig) : $signed(sig);
endfunction

// Result word and {OF, UF, NX} for a + b or a - b.
function automatic void modelAddSub(
  input  logic [15:0] a,
  input  logic [15:0] b,
  input  logic        sub,
  output logic [15:0] res,
  output logic [2:0]  flg
);
  logic [15:0]        bEff;
  logic               nanA, nanB, infA, infB;
  logic signed [63:0] sum;
  logic [63:0]        mag, q, rem, half;
  logic               sgn, nx, of;
  int                 p, sh;
  bEff = {b[15] ^ sub, b[14:0]};
  nanA = (&a[14:10]) && (|a[9:0]);
  nanB = (&b[14:10]) && (|b[9:0]);
  infA = (&a[14:10]) && !(|a[9:0]);
  infB = (&b[14:10]) && !(|b[9:0]);
  flg  = 3'b000;
  if (nanA || nanB || (infA && infB && (a[15] != bEff[15]))) begin
    res = 16'h7E00;
  end else if (infA) begin
    res = a;
  end else if (infB) begin
    res = bEff;
  end else begin
    sum = toUnits(a) + toUnits(bEff);
    sgn = (sum < 64'sd0);
    mag = sgn ? 64'(-sum) : 64'(sum);
    if (sum == 64'sd0) begin
      // Negative only when both addends are negative zeros.
      res = {a[15] & bEff[15], 15'd0};
    end else if (mag < 64'd2048) begin
      // Small sums are exact and the unit count is the bit pattern itself.
      res = {sgn, 4'd0, mag[10:0]};
    end else begin
      p = 0;
      for (int i = 0; i < 64; i++) begin
        if (mag[i]) begin
          p = i;
        end
      end
      sh   = p - 10;
      q    = mag >> sh;
      rem  = mag & ((64'd1 << sh) - 64'd1);
      half = 64'd1 << (sh - 1);
      nx   = (rem != 64'd0);
      if ((rem > half) || ((rem == half) && q[0])) begin
        q = q + 64'd1;
      end
      // Round-up carry into a new binade.
      if (q == 64'd2048) begin
        q  = 64'd1024;
        sh = sh + 1;
      end
      of = (sh + 1 > 30);
      if (of) begin
        res = sgn ? 16'hFC00 : 16'h7C00;
      end else begin
        res = {sgn, 5'(sh + 1), q[9:0]};
      end
      // Normal results only here, never tiny.
      flg = {of, 1'b0, nx | of};
    end
  end
endfunction

`endif

/* test/fpuAddSubTb.sv */
// Self-checking testbench for fpuAddSub; random pairs come from seed 75 and cover no full IEEE corpus.
module fpuAddSubTb;

  `include "fpuAddSubModel.svh"

  localparam int timeoutCycles = 40;

  logic                       clk;
  logic                       rst;
  logic                       start;
  logic                       sub;
  logic [15:0]                opA;
  logic [15:0]                opB;
  logic [15:0]                result;
  fpuTypesPkg::opStatusFlag_t flags;
  logic                       busy;
  logic                       done;

  int          errors;
  int          checks;
  int          errBefore;
  int          ea;
  bit          timedOut;
  logic [15:0] a;
  logic [15:0] b;

  fpuAddSub DUT (
    .clk, .rst, .start, .sub, .opA, .opB, .result, .flags, .busy, .done
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Alignment steps expected from the exponent gap.
  function automatic int alignCount(input logic [15:0] x, input logic [15:0] y);
    int ex, ey, d;
    ex = (x[14:10] == 5'd0) ? 1 : int'(x[14:10]);
    ey = (y[14:10] == 5'd0) ? 1 : int'(y[14:10]);
    d  = (ex > ey) ? ex - ey : ey - ex;
    if ((&x[14:10]) || (&y[14:10])) begin
      d = 0;
    end
    return (d > 14) ? 14 : d;
  endfunction

  task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic reportTest(input string name);
    $display("Test %s: %s, %0d errors", name, (errors == errBefore) ? "ok" : "failed",
             errors - errBefore);
    errBefore = errors;
  endtask

  // One operation; poke raises start again while the unit is busy.
  task automatic runOp(input logic [15:0] x, input logic [15:0] y, input logic s, input bit poke);
    logic [15:0] expRes;
    logic [2:0]  expFlg;
    int          expCycles;
    int          cycles;
    logic        seen;
    string       tag;
    if (timedOut) begin
      return;
    end
    modelAddSub(x, y, s, expRes, expFlg);
    expCycles = alignCount(x, y) + 4;
    tag = $sformatf("%h %s %h", x, s ? "-" : "+", y);
    @(posedge clk);
    start <= 1'b1;
    sub   <= s;
    opA   <= x;
    opB   <= y;
    @(posedge clk);
    start <= 1'b0;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && (cycles < timeoutCycles)) begin
      @(posedge clk);
      cycles++;
      if (poke) begin
        start <= (cycles == 2);
        opA   <= ~x;
        opB   <= ~y;
      end
      @(negedge clk);
      seen = done;
      if (!seen) begin
        checkValue({"busy before done for ", tag}, 16'(busy), 16'h0001);
      end
    end
    if (!seen) begin
      errors++;
      timedOut = 1'b1;
      $display("Timeout: done never came within %0d cycles for %s", timeoutCycles, tag);
    end else begin
      checks++;
      if (cycles != expCycles) begin
        errors++;
        $display("Latency wrong for %s: done after %0d cycles, expected %0d",
                 tag, cycles, expCycles);
      end
      checkValue({"result for ", tag}, result, expRes);
      checkValue({"flags for ", tag}, 16'(flags), 16'(expFlg));
      checkValue({"busy at done for ", tag}, 16'(busy), 16'h0000);
    end
  endtask

  initial begin
    rst       = 1'b1;
    start     = 1'b0;
    sub       = 1'b0;
    opA       = 16'h0000;
    opB       = 16'h0000;
    errors    = 0;
    checks    = 0;
    errBefore = 0;
    timedOut  = 1'b0;
    void'($urandom(75));
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    checkValue("result after reset", result, 16'h0000);
    checkValue("flags after reset", 16'(flags), 16'h0000);
    checkValue("busy after reset", 16'(busy), 16'h0000);
    checkValue("done after reset", 16'(done), 16'h0000);
    runOp(16'h3C00, 16'h3C00, 1'b0, 1'b0);
    runOp(16'h4200, 16'h3C00, 1'b1, 1'b0);
    runOp(16'h3E00, 16'h3400, 1'b0, 1'b0);
    reportTest("reset and exact sums");

    // Gaps 0 to 20; past 14 the unit stops shifting.
    for (int d = 0; d <= 20; d++) begin
      a = {1'b0, 5'd25, 10'($urandom)};
      b = {1'($urandom), 5'(25 - d), 10'($urandom)};
      runOp(a, b, 1'(d % 2), (d % 3) == 0);
    end
    reportTest("latency and start while busy");

    runOp(16'h3C00, 16'h0001, 1'b0, 1'b0);
    runOp(16'h3C00, 16'h1000, 1'b0, 1'b0);
    runOp(16'h3C01, 16'h1000, 1'b0, 1'b0);
    runOp(16'h3C00, 16'h0001, 1'b1, 1'b0);
    runOp(16'h4000, 16'h3BFF, 1'b1, 1'b0);
    runOp(16'h3C01, 16'h3C00, 1'b1, 1'b0);
    runOp(16'h7000, 16'h1234, 1'b0, 1'b0);
    runOp(16'h6400, 16'h0400, 1'b1, 1'b0);
    for (int k = 0; k < 24; k++) begin
      ea = 16 + int'($urandom % 14);
      a  = {1'($urandom), 5'(ea), 10'($urandom)};
      b  = {1'($urandom), 5'(ea - 8 - k % 8), 10'($urandom)};
      runOp(a, b, 1'($urandom), 1'b0);
    end
    reportTest("rounding and alignment");

    runOp(16'h0001, 16'h0001, 1'b0, 1'b0);
    runOp(16'h03FF, 16'h0001, 1'b0, 1'b0);
    runOp(16'h0200, 16'h0200, 1'b0, 1'b0);
    runOp(16'h0400, 16'h0001, 1'b1, 1'b0);
    runOp(16'h0401, 16'h0400, 1'b1, 1'b0);
    runOp(16'h8001, 16'h8001, 1'b0, 1'b0);
    runOp(16'h7BFF, 16'h7BFF, 1'b0, 1'b0);
    runOp(16'h7BFF, 16'h3C00, 1'b0, 1'b0);
    runOp(16'h7BFF, 16'h5000, 1'b0, 1'b0);
    runOp(16'hFBFF, 16'h7BFF, 1'b1, 1'b0);
    runOp(16'h7800, 16'h7800, 1'b0, 1'b0);
    runOp(16'h7BFF, 16'h0001, 1'b1, 1'b0);
    reportTest("subnormals and limits");

    runOp(16'h7E00, 16'h3C00, 1'b0, 1'b0);
    runOp(16'h3C00, 16'h7C01, 1'b1, 1'b0);
    runOp(16'h7C00, 16'h3C00, 1'b0, 1'b0);
    runOp(16'h3C00, 16'h7C00, 1'b1, 1'b0);
    runOp(16'h7C00, 16'h7C00, 1'b1, 1'b0);
    runOp(16'h7C00, 16'hFC00, 1'b0, 1'b0);
    runOp(16'hFC00, 16'h7C00, 1'b1, 1'b0);
    runOp(16'h0000, 16'h0000, 1'b0, 1'b0);
    runOp(16'h8000, 16'h8000, 1'b0, 1'b0);
    runOp(16'h8000, 16'h0000, 1'b1, 1'b0);
    runOp(16'h0000, 16'h0000, 1'b1, 1'b0);
    runOp(16'h8000, 16'h0000, 1'b0, 1'b0);
    runOp(16'h3C00, 16'h3C00, 1'b1, 1'b0);
    runOp(16'hBC00, 16'h3C00, 1'b0, 1'b0);
    reportTest("special values");

    for (int k = 0; k < 2000; k++) begin
      a = 16'($urandom);
      b = 16'($urandom);
      // Equal exponents now and then give cancellation.
      if (($urandom % 4) == 0) begin
        b[14:10] = a[14:10];
      end
      runOp(a, b, 1'($urandom), 1'b0);
    end
    reportTest("random pairs");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : fpuAddSubTb

/* list.f */
+incdir+src
+incdir+test
src/fpuTypesPkg.sv
src/fpuCtrlPkg.sv
src/fpuAddSubCtrl.sv
src/fpuShiftCounter.sv
src/fpuOperandPrep.sv
src/fpuAlignShifter.sv
src/fpuNormalizer16.sv
src/fpuAddSub.sv
test/fpuAddSubTb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f list.f --top-module fpuAddSubTb -o fpuAddSubSim > build.log 2>&1 \
  && ./obj_dir/fpuAddSubSim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0
